// File: include/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// data path
`define DMA_DATA_W      32      // bits per memory word
`define DMA_ADDR_W      16      // word address, not byte

// job size
`define DMA_LEN_W       16      // word count register width

// staging buffer between read and write side
`define DMA_FIFO_DEPTH  8       // keep a power of two

// source memory read port
`define DMA_RD_LAT      1       // cycles from rd_req_o to rd_data_i

`endif

// File: logic/dma_pkg.sv
`include "dma_params.svh"

package dma_pkg;

    // copy job as held by the register block
    // stays frozen while a copy runs
    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] src_addr;   // first source word
        logic [`DMA_ADDR_W-1:0] dst_addr;   // first destination word
        logic [`DMA_LEN_W-1:0]  len;        // words to move, 0 means nothing
    } dma_cfg_t;

    // one word toward the destination memory
    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] addr;       // word address
        logic [`DMA_DATA_W-1:0] data;       // payload from fifo head
    } dma_wr_req_t;

endpackage

// File: logic/dma_fifo.sv
`timescale 1ns/10ps

module dma_fifo #(
    parameter int DATA_WIDTH = 32,              // word width
    parameter int FIFO_DEPTH = 8                // entries, power of two
) (
    input  logic                  clk,
    input  logic                  rst_n,        // clears pointers only
    input  logic                  wren_i,       // push strobe
    input  logic                  rden_i,       // pop strobe
    input  logic [DATA_WIDTH-1:0] wdata_i,
    output logic [DATA_WIDTH-1:0] rdata_o,      // head entry, show-ahead
    output logic                  full_o,
    output logic                  empty_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);  // index bits

    // extra msb tells full from empty when low bits match
    logic [PTR_W:0] wr_ptr, wr_ptr_n;
    logic [PTR_W:0] rd_ptr, rd_ptr_n;

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];    // storage, no reset

    always_comb begin
        wr_ptr_n = wr_ptr;
        rd_ptr_n = rd_ptr;
        if (wren_i) begin
            wr_ptr_n = wr_ptr + 1'b1;           // wraps through the extra bit
        end
        if (rden_i) begin
            rd_ptr_n = rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr_n;
            rd_ptr <= rd_ptr_n;
        end
    end

    always_ff @(posedge clk) begin
        if (wren_i) begin
            mem[wr_ptr[PTR_W-1:0]] <= wdata_i;
        end
    end

    assign rdata_o = mem[rd_ptr[PTR_W-1:0]];    // head visible without a pop

    assign empty_o = (wr_ptr == rd_ptr);
    // same slot, different lap
    assign full_o  = (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0])
                   & (wr_ptr[PTR_W] != rd_ptr[PTR_W]);

    // producer and consumer must respect the flags, fifo does not guard itself
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) wren_i |-> !full_o
    ) else $error("dma_fifo: push while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) rden_i |-> !empty_o
    ) else $error("dma_fifo: pop while empty");

endmodule

// File: logic/dma_cfg_regs.sv
`timescale 1ns/10ps
`include "dma_params.svh"

module dma_cfg_regs
    import dma_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cfg_we_i,     // host write strobe
    input  logic [1:0]             cfg_addr_i,   // 0 src, 1 dst, 2 len, 3 ctrl
    input  logic [`DMA_DATA_W-1:0] cfg_wdata_i,
    input  logic                   finish_i,     // last write accepted
    output logic [`DMA_DATA_W-1:0] cfg_rdata_o,  // comb readback
    output dma_cfg_t               cfg_o,        // job to both engines
    output logic                   start_o       // one cycle kick
);

    dma_cfg_t cfg_q;
    logic     busy_q;
    logic     done_q;
    logic     go;

    // go is dropped while running or for an empty job
    assign go = cfg_we_i && (cfg_addr_i == 2'd3) && cfg_wdata_i[0]
              && !busy_q && (cfg_q.len != '0);

    assign start_o = go;   // engines load on the go cycle
    assign cfg_o   = cfg_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (cfg_we_i && !busy_q) begin   // frozen during a copy
            case (cfg_addr_i)
                2'd0:    cfg_q.src_addr <= cfg_wdata_i[`DMA_ADDR_W-1:0];
                2'd1:    cfg_q.dst_addr <= cfg_wdata_i[`DMA_ADDR_W-1:0];
                2'd2:    cfg_q.len      <= cfg_wdata_i[`DMA_LEN_W-1:0];
                default: ;                          // ctrl has no storage
            endcase
        end
    end

    // busy up the cycle after go, down the cycle after finish
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (go) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;   // new job clears old status
            end else if (finish_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            2'd0: cfg_rdata_o[`DMA_ADDR_W-1:0] = cfg_q.src_addr;
            2'd1: cfg_rdata_o[`DMA_ADDR_W-1:0] = cfg_q.dst_addr;
            2'd2: cfg_rdata_o[`DMA_LEN_W-1:0]  = cfg_q.len;
            2'd3: cfg_rdata_o[1:0]             = {done_q, busy_q};
            default: ;
        endcase
    end

    // finish only arrives for a running job
    a_finish_busy: assert property (
        @(posedge clk) disable iff (!rst_n) finish_i |-> busy_q
    ) else $error("dma_cfg_regs: finish while idle");

endmodule

// File: logic/dma_rd_engine.sv
`timescale 1ns/10ps
`include "dma_params.svh"

module dma_rd_engine
    import dma_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,       // load a new job
    input  dma_cfg_t               cfg_i,
    input  logic                   fifo_full_i,   // only watched by the check below
    input  logic                   fifo_pop_i,    // write side freed a slot
    output logic                   rd_req_o,      // one word per strobe
    output logic [`DMA_ADDR_W-1:0] rd_addr_o,
    input  logic [`DMA_DATA_W-1:0] rd_data_i,     // no valid, arrives after fixed latency
    output logic                   fifo_push_o,
    output logic [`DMA_DATA_W-1:0] fifo_wdata_o
);

    localparam int CRED_W = $clog2(`DMA_FIFO_DEPTH) + 1;  // must hold DEPTH itself

    logic [`DMA_ADDR_W-1:0] src_addr;     // next word to fetch
    logic [`DMA_LEN_W-1:0]  remaining;    // words not yet requested
    logic [CRED_W-1:0]      credits;      // free fifo slots not claimed by a read
    logic [`DMA_RD_LAT-1:0] req_pipe;     // request strobe delayed to data return
    logic                   issue;

    // a credit covers both the in-flight word and its fifo slot
    assign issue = (remaining != '0) && (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
            credits   <= '0;
            rd_req_o  <= 1'b0;
            req_pipe  <= '0;
        end else begin
            if (start_i) begin
                remaining <= cfg_i.len;
                credits   <= CRED_W'(`DMA_FIFO_DEPTH);
            end else begin
                remaining <= remaining - `DMA_LEN_W'(issue);
                credits   <= credits + CRED_W'(fifo_pop_i) - CRED_W'(issue);
            end
            rd_req_o    <= issue && !start_i;   // registered, shows next cycle
            req_pipe[0] <= rd_req_o;
            for (int i = 1; i < `DMA_RD_LAT; i++) begin
                req_pipe[i] <= req_pipe[i-1];
            end
        end
    end

    // source address counter
    always_ff @(posedge clk) begin
        if (start_i) begin
            src_addr <= cfg_i.src_addr;
        end else if (issue) begin
            src_addr  <= src_addr + 1'b1;
            rd_addr_o <= src_addr;
        end
    end

    assign fifo_push_o  = req_pipe[`DMA_RD_LAT-1];   // data lands this cycle
    assign fifo_wdata_o = rd_data_i;

    // credits should make this impossible
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) fifo_push_o |-> !fifo_full_i
    ) else $error("dma_rd_engine: push into full fifo");

endmodule

// File: logic/dma_wr_engine.sv
`timescale 1ns/10ps
`include "dma_params.svh"

module dma_wr_engine
    import dma_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  dma_cfg_t               cfg_i,
    input  logic                   fifo_empty_i,
    input  logic [`DMA_DATA_W-1:0] fifo_rdata_i,  // show-ahead head
    output logic                   fifo_pop_o,
    input  logic                   wr_stall_i,    // destination not ready
    output logic                   wr_en_o,
    output dma_wr_req_t            wr_req_o,
    output logic                   finish_o       // pulse on last accepted write
);

    logic [`DMA_ADDR_W-1:0] dst_addr;
    logic [`DMA_LEN_W-1:0]  remaining;   // writes still owed
    logic                   accept;

    // offered as soon as the head is valid
    assign wr_en_o       = !fifo_empty_i && (remaining != '0);
    assign wr_req_o.addr = dst_addr;
    assign wr_req_o.data = fifo_rdata_i;

    assign accept     = wr_en_o && !wr_stall_i;
    assign fifo_pop_o = accept;               // pop with the accepted write
    assign finish_o   = accept && (remaining == `DMA_LEN_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (start_i) begin
            remaining <= cfg_i.len;
        end else if (accept) begin
            remaining <= remaining - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            dst_addr <= cfg_i.dst_addr;
        end else if (accept) begin
            dst_addr <= dst_addr + 1'b1;
        end
    end

    // stalled write must be held until taken, fifo head and address included
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en_o && wr_stall_i) |=> (wr_en_o && $stable(wr_req_o))
    ) else $error("dma_wr_engine: request changed under stall");

endmodule

// File: logic/dma_top.sv
`timescale 1ns/10ps
`include "dma_params.svh"

module dma_top
    import dma_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // host side
    input  logic                   cfg_we_i,
    input  logic [1:0]             cfg_addr_i,
    input  logic [`DMA_DATA_W-1:0] cfg_wdata_i,
    output logic [`DMA_DATA_W-1:0] cfg_rdata_o,
    // source memory
    output logic                   rd_req_o,
    output logic [`DMA_ADDR_W-1:0] rd_addr_o,
    input  logic [`DMA_DATA_W-1:0] rd_data_i,
    // destination memory
    output logic                   wr_en_o,
    output dma_wr_req_t            wr_req_o,
    input  logic                   wr_stall_i
);

    dma_cfg_t               cfg;
    logic                   start;
    logic                   finish;
    logic                   fifo_push, fifo_pop;
    logic                   fifo_full, fifo_empty;
    logic [`DMA_DATA_W-1:0] fifo_wdata, fifo_rdata;

    dma_cfg_regs i_cfg_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_we_i   (cfg_we_i),
        .cfg_addr_i (cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i),
        .finish_i   (finish),
        .cfg_rdata_o(cfg_rdata_o),
        .cfg_o      (cfg),
        .start_o    (start)
    );

    dma_rd_engine i_rd_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start),
        .cfg_i       (cfg),
        .fifo_full_i (fifo_full),
        .fifo_pop_i  (fifo_pop),   // credit return
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_i   (rd_data_i),
        .fifo_push_o (fifo_push),
        .fifo_wdata_o(fifo_wdata)
    );

    dma_fifo #(
        .DATA_WIDTH(`DMA_DATA_W),
        .FIFO_DEPTH(`DMA_FIFO_DEPTH)
    ) i_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wren_i (fifo_push),
        .rden_i (fifo_pop),
        .wdata_i(fifo_wdata),
        .rdata_o(fifo_rdata),
        .full_o (fifo_full),
        .empty_o(fifo_empty)
    );

    dma_wr_engine i_wr_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start),
        .cfg_i       (cfg),
        .fifo_empty_i(fifo_empty),
        .fifo_rdata_i(fifo_rdata),
        .fifo_pop_o  (fifo_pop),
        .wr_stall_i  (wr_stall_i),
        .wr_en_o     (wr_en_o),
        .wr_req_o    (wr_req_o),
        .finish_o    (finish)
    );

endmodule

// File: sim/tb_dma.sv
`timescale 1ns/10ps
`include "dma_params.svh"

module tb_dma
    import dma_pkg::*;
();

    localparam logic [31:0] SEED = 32'h7e85;
    localparam int NUM_COPIES     = 20;
    localparam int TIMEOUT_CYCLES = NUM_COPIES * (64 * 4 + 20);  // worst case per copy

    logic                   clk;
    logic                   rst_n;
    logic                   cfg_we_i;
    logic [1:0]             cfg_addr_i;
    logic [`DMA_DATA_W-1:0] cfg_wdata_i;
    logic [`DMA_DATA_W-1:0] cfg_rdata_o;
    logic                   rd_req_o;
    logic [`DMA_ADDR_W-1:0] rd_addr_o;
    logic [`DMA_DATA_W-1:0] rd_data_i;
    logic                   wr_en_o;
    dma_wr_req_t            wr_req_o;
    logic                   wr_stall_i;

    logic [31:0]            rng;                  // host side random state
    logic [31:0]            stall_rng;            // port side random state
    logic [`DMA_DATA_W-1:0] src_mem [65536];      // source memory model
    logic [`DMA_DATA_W-1:0] dst_mem [65536];      // accepted writes land here
    dma_wr_req_t            exp_q [$];            // expected writes, in order
    int unsigned            rd_budget;            // reads still allowed for this copy
    logic [`DMA_ADDR_W-1:0] rd_exp_addr;          // next source word to be fetched
    int unsigned            wr_count;             // accepted writes this copy
    logic                   rd_pending;           // answer due next cycle
    logic [`DMA_DATA_W-1:0] rd_next;
    logic                   stall_hold;           // last cycle was a stalled offer
    dma_wr_req_t            held_req;
    int unsigned            cycle_cnt;

    dma_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_we_i   (cfg_we_i),
        .cfg_addr_i (cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i),
        .cfg_rdata_o(cfg_rdata_o),
        .rd_req_o   (rd_req_o),
        .rd_addr_o  (rd_addr_o),
        .rd_data_i  (rd_data_i),
        .wr_en_o    (wr_en_o),
        .wr_req_o   (wr_req_o),
        .wr_stall_i (wr_stall_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [`DMA_DATA_W-1:0] got,
                              input logic [`DMA_DATA_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_wr_req(input string name, input dma_wr_req_t got,
                                input dma_wr_req_t exp);
        if (got !== exp) begin
            report_failure($sformatf(
                "Fail %s: got addr 0x%h data 0x%h, expected addr 0x%h data 0x%h",
                name, got.addr, got.data, exp.addr, exp.data));
        end
    endtask

    // one cycle host write strobe
    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(posedge clk);
        #1;
        cfg_we_i    = 1'b0;
    endtask

    // comb readback sampled at the falling edge
    task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        cfg_we_i   = 1'b0;
        cfg_addr_i = addr;
        @(negedge clk);
        data = cfg_rdata_o;
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[1]) begin   // poll status until done is set
            read_reg(2'd3, st);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run length guard
    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt >= TIMEOUT_CYCLES) begin
                report_failure($sformatf("timeout after %0d cycles, copy never completed",
                                         cycle_cnt));
            end
        end
    end

    // port drivers just after the rising edge
    initial begin
        stall_rng = xorshift32(SEED ^ 32'hffff_0000);
        forever begin
            @(posedge clk);
            #1;
            stall_rng  = xorshift32(stall_rng);
            wr_stall_i = (stall_rng % 3) == 0;              // about a third stalled
            rd_data_i  = rd_pending ? rd_next : stall_rng;  // junk when nothing due
        end
    end

    // monitor samples settled outputs at the falling edge
    initial begin
        rd_pending = 1'b0;
        stall_hold = 1'b0;
        held_req   = '0;
        wait (rst_n);
        forever begin
            @(negedge clk);
            if (rd_req_o) begin
                if (rd_budget == 0) begin
                    report_failure("read request seen with no copy word left to fetch");
                end
                check_word("rd_addr_o", {16'h0, rd_addr_o}, {16'h0, rd_exp_addr});
                rd_exp_addr++;
                rd_budget--;
                rd_next = src_mem[rd_addr_o];
            end
            rd_pending = rd_req_o;   // fixed one cycle latency
            if (stall_hold) begin
                check_word("wr_en_o under stall", {31'b0, wr_en_o}, 32'h1);
                check_wr_req("wr_req_o under stall", wr_req_o, held_req);
            end
            if (wr_en_o) begin
                if (exp_q.size() == 0) begin
                    report_failure("write offered with no word expected");
                end
                check_wr_req("wr_req_o", wr_req_o, exp_q[0]);
                if (!wr_stall_i) begin          // taken on the coming edge
                    dst_mem[wr_req_o.addr] = wr_req_o.data;
                    void'(exp_q.pop_front());
                    wr_count++;
                end
            end
            stall_hold = wr_en_o && wr_stall_i;
            held_req   = wr_req_o;
        end
    end

    initial begin
        logic [31:0] rd_val;
        logic [31:0] regs [3];
        int unsigned len;
        int unsigned src;
        int unsigned dst;
        dma_wr_req_t req;

        rst_n       = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        rd_data_i   = '0;
        wr_stall_i  = 1'b0;
        rd_budget   = 0;
        rd_exp_addr = '0;
        wr_count    = 0;
        rng         = SEED;
        for (int a = 0; a < 65536; a++) begin
            rng        = xorshift32(rng);
            src_mem[a] = rng;
            dst_mem[a] = {16'hdead, 16'(a)};   // marks words never written
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset values
        for (int a = 0; a < 4; a++) begin
            read_reg(2'(a), rd_val);
            check_word($sformatf("cfg_rdata_o reg %0d after reset", a), rd_val, '0);
        end

        // plain register readback of the low 16 stored bits
        for (int a = 0; a < 3; a++) begin
            rng     = xorshift32(rng);
            regs[a] = rng;
            write_reg(2'(a), regs[a]);
        end
        for (int a = 0; a < 3; a++) begin
            read_reg(2'(a), rd_val);
            check_word($sformatf("cfg_rdata_o reg %0d", a), rd_val, {16'h0, regs[a][15:0]});
        end

        for (int n = 0; n < NUM_COPIES; n++) begin
            rng = xorshift32(rng);
            len = (rng % 64) + 1;
            rng = xorshift32(rng);
            src = rng % 32'h7fc0;                  // source in lower half
            rng = xorshift32(rng);
            dst = 32'h8000 + (rng % 32'h7fc0);     // destination in upper half
            write_reg(2'd0, src);
            write_reg(2'd1, dst);
            write_reg(2'd2, len);
            read_reg(2'd0, rd_val);
            check_word("cfg_rdata_o src", rd_val, src);
            read_reg(2'd1, rd_val);
            check_word("cfg_rdata_o dst", rd_val, dst);
            read_reg(2'd2, rd_val);
            check_word("cfg_rdata_o len", rd_val, len);

            for (int i = 0; i < int'(len); i++) begin
                req.addr = 16'(dst + i);
                req.data = src_mem[src + i];
                exp_q.push_back(req);
            end
            rd_budget   = len;
            rd_exp_addr = 16'(src);
            wr_count    = 0;
            write_reg(2'd3, 32'h1);                // go
            read_reg(2'd3, rd_val);
            check_word("status after go", rd_val, 32'h1);   // busy, done cleared

            if (len >= 16) begin   // long enough to stay busy through these
                write_reg(2'd0, ~src);
                write_reg(2'd1, ~dst);
                write_reg(2'd2, 32'h5);
                write_reg(2'd3, 32'h1);            // second go must be dropped
                read_reg(2'd0, rd_val);
                check_word("src written while busy", rd_val, src);
                read_reg(2'd1, rd_val);
                check_word("dst written while busy", rd_val, dst);
                read_reg(2'd2, rd_val);
                check_word("len written while busy", rd_val, len);
            end

            wait_done();
            read_reg(2'd3, rd_val);
            check_word("status after copy", rd_val, 32'h2);  // done, not busy
            check_word("write count", wr_count, len);
            check_word("rd_req_o count", len - rd_budget, len);
            for (int i = 0; i < int'(len); i++) begin
                check_word($sformatf("dst word 0x%h", 16'(dst + i)),
                           dst_mem[dst + i], src_mem[src + i]);
            end
        end

        // go with an empty job must be ignored
        write_reg(2'd2, 32'h0);
        write_reg(2'd3, 32'h1);
        read_reg(2'd3, rd_val);
        check_word("status after zero length go", rd_val, 32'h2);  // old done kept
        repeat (10) @(posedge clk);   // monitor flags any read or write here
        read_reg(2'd3, rd_val);
        check_word("status after zero length idle", rd_val, 32'h2);

        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
logic/dma_pkg.sv
logic/dma_fifo.sv
logic/dma_cfg_regs.sv
logic/dma_rd_engine.sv
logic/dma_wr_engine.sv
logic/dma_top.sv
sim/tb_dma.sv

// File: run.sh
#!/usr/bin/env bash
# builds the copy engine testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module tb_dma \
    -o tb_dma

./obj_dir/tb_dma
